// File: privileged.f
source/privPkg.sv
source/privDecoder.sv
source/csrFile.sv
source/trapUnit.sv
source/privileged.sv
tests/privilegedTb.sv

// File: runSim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f privileged.f \
  --top-module privilegedTb \
  -o privilegedSim

simOut=$(./obj_dir/privilegedSim)
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -q "Result: PASSED"; then
  exit 0
else
  exit 1
fi

// File: tests/privilegedTb.sv
// testbench for the privileged unit with a CSR reference model and trap checks
`timescale 1ns/1ps

module privilegedTb;

  localparam int halfPeriod = 50;
  localparam int settleTime = 10;
  localparam int trapTimeout = 8;
  localparam privPkg::xlenT nopInstr    = 32'h0000_0013;
  localparam privPkg::xlenT ecallInstr  = 32'h0000_0073;
  localparam privPkg::xlenT mretInstr   = 32'h3020_0073;
  localparam privPkg::xlenT sretInstr   = 32'h1020_0073;
  localparam privPkg::xlenT sfenceInstr = 32'h1200_0073;
  // legal bits, low two bits of tvec and epc always read zero
  localparam privPkg::xlenT alignMask   = 32'hffff_fffc;
  localparam privPkg::xlenT excDelMask  = 32'h0000_ffff;
  localparam privPkg::xlenT intBitsMask = 32'h0000_0888;

  logic clk;
  logic rstN;
  logic stallD, stallE, stallM, stallW;
  logic flushD, flushE, flushM;
  privPkg::instrFaultT faultF;
  logic illegalInstrD;
  logic instrValidM;
  privPkg::xlenT instrM;
  privPkg::xlenT pcM;
  logic csrReadM;
  logic csrWriteM;
  privPkg::xlenT srcAM;
  logic loadAccessFaultM;
  logic storeAccessFaultM;
  privPkg::xlenT memAdrM;
  privPkg::intLinesT intM;
  privPkg::xlenT csrReadValW;
  privPkg::xlenT privNextPcM;
  logic trapM, retM, tlbFlushM;
  privPkg::privModeT privilegeModeW;
  logic statusSum, statusMxr, statusMprv;
  logic [1:0] statusMpp;

  logic [15:0] lfsrState;
  privPkg::csrAddrT regAddr [7];
  privPkg::xlenT regMask [7];
  privPkg::xlenT regModel [7];

  privileged privileged_inst (.*);

  always #halfPeriod clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // one lfsr step per bit taken
  task automatic takeBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  function automatic privPkg::xlenT csrInstr(input logic [2:0] funct3,
                                             input privPkg::csrAddrT addr,
                                             input logic [4:0] rs1, input logic [4:0] rd);
    return {addr, rs1, funct3, rd, 7'b1110011};
  endfunction

  task automatic failRun(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input privPkg::xlenT got,
                         input privPkg::xlenT expected);
    assert (got === expected)
    else failRun($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected));
  endtask

  task automatic checkBit(input string name, input logic got, input logic expected);
    assert (got === expected)
    else failRun($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected));
  endtask

  task automatic checkMode(input privPkg::privModeT expected);
    assert (privilegeModeW === expected)
    else failRun($sformatf("Mismatch privilegeModeW: got 0x%0h, expected 0x%0h",
                           privilegeModeW, expected));
  endtask

  // status bits that go out to the MMU
  task automatic checkMmuBits(input logic mprv, input logic sum, input logic mxr);
    checkBit("statusMprv", statusMprv, mprv);
    checkBit("statusSum", statusSum, sum);
    checkBit("statusMxr", statusMxr, mxr);
  endtask

  // quiet memory stage, no faults, no interrupts
  task automatic idle();
    instrValidM = 1'b0;
    instrM = nopInstr;
    csrReadM = 1'b0;
    csrWriteM = 1'b0;
    srcAM = '0;
    faultF = '0;
    flushD = 1'b0;
    intM = '0;
  endtask

  // apply at the falling edge, leave time for the combinational outputs
  task automatic drive(input privPkg::xlenT instr, input privPkg::xlenT pc,
                       input logic rd, input logic wr, input privPkg::xlenT src);
    instrValidM = 1'b1;
    instrM = instr;
    pcM = pc;
    csrReadM = rd;
    csrWriteM = wr;
    srcAM = src;
    #settleTime;
  endtask

  task automatic endCycle();
    @(posedge clk);
    @(negedge clk);
    idle();
  endtask

  task automatic writeCsr(input logic [2:0] funct3, input privPkg::csrAddrT addr,
                          input privPkg::xlenT data);
    drive(csrInstr(funct3, addr, 5'd2, 5'd0), 32'h0, 1'b1, 1'b1, data);
    checkBit("trapM", trapM, 1'b0);
    endCycle();
  endtask

  // csrrs with x0, value shows up one edge later
  task automatic expectCsr(input string name, input privPkg::csrAddrT addr,
                           input privPkg::xlenT expected);
    drive(csrInstr(3'b010, addr, 5'd0, 5'd1), 32'h0, 1'b1, 1'b0, 32'h0);
    checkBit("trapM", trapM, 1'b0);
    endCycle();
    checkEq(name, csrReadValW, expected);
  endtask

  // fetch inputs only last one cycle
  task automatic waitForTrap(output int edges);
    edges = 0;
    while (!trapM) begin
      if (edges >= trapTimeout) failRun("timeout while waiting for trapM to rise");
      @(posedge clk);
      @(negedge clk);
      edges++;
      faultF = '0;
      #settleTime;
    end
  endtask

  task automatic observeNoTrap(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      checkBit("trapM", trapM, 1'b0);
      @(posedge clk);
      @(negedge clk);
      #settleTime;
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    int idx;
    int edges;
    logic [31:0] bits;
    logic [31:0] data;
    logic [2:0] funct3;
    clk = 1'b0;
    rstN = 1'b0;
    {stallD, stallE, stallM, stallW} = '0;
    {flushE, flushM} = '0;
    illegalInstrD = 1'b0;
    loadAccessFaultM = 1'b0;
    storeAccessFaultM = 1'b0;
    memAdrM = '0;
    pcM = '0;
    idle();
    lfsrState = 16'd68;
    regAddr = '{privPkg::csrMtvec, privPkg::csrMepc, privPkg::csrMedeleg,
                privPkg::csrMideleg, privPkg::csrMie, privPkg::csrStvec, privPkg::csrSepc};
    regMask = '{alignMask, alignMask, excDelMask, intBitsMask, intBitsMask,
                alignMask, alignMask};
    regModel = '{default: 32'h0};
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    // reset state
    #settleTime;
    checkMode(privPkg::modeM);
    checkBit("trapM", trapM, 1'b0);
    checkBit("retM", retM, 1'b0);
    checkBit("tlbFlushM", tlbFlushM, 1'b0);
    @(negedge clk);
    expectCsr("mstatus", privPkg::csrMstatus, 32'h0);

    // mprv, sum and mxr reach their outputs one at a time
    writeCsr(3'b001, privPkg::csrMstatus, 32'h0002_0000);
    checkMmuBits(1'b1, 1'b0, 1'b0);
    writeCsr(3'b001, privPkg::csrMstatus, 32'h0004_0000);
    checkMmuBits(1'b0, 1'b1, 1'b0);
    writeCsr(3'b001, privPkg::csrMstatus, 32'h0008_0000);
    checkMmuBits(1'b0, 1'b0, 1'b1);
    writeCsr(3'b001, privPkg::csrMstatus, 32'h0);
    checkMmuBits(1'b0, 1'b0, 1'b0);

    // sfence.vma asks for a TLB flush
    drive(sfenceInstr, 32'h0000_0040, 1'b0, 1'b0, 32'h0);
    checkBit("trapM", trapM, 1'b0);
    checkBit("tlbFlushM", tlbFlushM, 1'b1);
    endCycle();

    // random csrrw, csrrs, csrrc against the model
    for (int n = 0; n < 32; n++) begin
      takeBits(3, bits);
      idx = int'(bits[2:0]) % 7;
      takeBits(2, bits);
      takeBits(32, data);
      case (bits[1:0] % 2'd3)
        2'd0: begin
          funct3 = 3'b001;
          regModel[idx] = data & regMask[idx];
        end
        2'd1: begin
          funct3 = 3'b010;
          regModel[idx] = (regModel[idx] | data) & regMask[idx];
        end
        default: begin
          funct3 = 3'b011;
          regModel[idx] = (regModel[idx] & ~data) & regMask[idx];
        end
      endcase
      writeCsr(funct3, regAddr[idx], data);
      expectCsr($sformatf("csr 0x%03h", regAddr[idx]), regAddr[idx], regModel[idx]);
    end

    // known vectors and delegation for the trap tests
    writeCsr(3'b001, privPkg::csrMtvec, 32'h0000_0100);
    writeCsr(3'b001, privPkg::csrStvec, 32'h0000_0300);
    writeCsr(3'b001, privPkg::csrMie, 32'h0);
    writeCsr(3'b001, privPkg::csrMideleg, 32'h0);
    writeCsr(3'b001, privPkg::csrMedeleg, 32'h0000_0100);

    // machine ecall and mret
    drive(ecallInstr, 32'h0000_1000, 1'b0, 1'b0, 32'h0);
    checkBit("trapM", trapM, 1'b1);
    checkEq("privNextPcM", privNextPcM, 32'h0000_0100);
    endCycle();
    checkMode(privPkg::modeM);
    expectCsr("mcause", privPkg::csrMcause, 32'd11);
    expectCsr("mepc", privPkg::csrMepc, 32'h0000_1000);
    expectCsr("mtval", privPkg::csrMtval, 32'h0);
    // clear mpp so mret drops to U
    writeCsr(3'b011, privPkg::csrMstatus, 32'h0000_1800);
    checkEq("statusMpp", {30'd0, statusMpp}, 32'h0);
    writeCsr(3'b001, privPkg::csrMepc, 32'h0000_2000);
    drive(mretInstr, 32'h0000_1004, 1'b0, 1'b0, 32'h0);
    checkBit("trapM", trapM, 1'b0);
    checkBit("retM", retM, 1'b1);
    checkEq("privNextPcM", privNextPcM, 32'h0000_2000);
    endCycle();
    checkMode(privPkg::modeU);

    // user ecall delegated to S, then sret
    drive(ecallInstr, 32'h0000_2000, 1'b0, 1'b0, 32'h0);
    checkBit("trapM", trapM, 1'b1);
    checkEq("privNextPcM", privNextPcM, 32'h0000_0300);
    endCycle();
    checkMode(privPkg::modeS);
    expectCsr("scause", privPkg::csrScause, 32'd8);
    expectCsr("sepc", privPkg::csrSepc, 32'h0000_2000);
    drive(sretInstr, 32'h0000_3000, 1'b0, 1'b0, 32'h0);
    checkBit("retM", retM, 1'b1);
    checkEq("privNextPcM", privNextPcM, 32'h0000_2000);
    endCycle();
    checkMode(privPkg::modeU);

    // mstatus read from U is illegal and goes to M
    drive(csrInstr(3'b010, privPkg::csrMstatus, 5'd0, 5'd1), 32'h0000_2004,
          1'b1, 1'b0, 32'h0);
    checkBit("trapM", trapM, 1'b1);
    checkEq("privNextPcM", privNextPcM, 32'h0000_0100);
    endCycle();
    checkMode(privPkg::modeM);
    expectCsr("mcause", privPkg::csrMcause, 32'd2);
    expectCsr("mtval", privPkg::csrMtval,
              csrInstr(3'b010, privPkg::csrMstatus, 5'd0, 5'd1));

    // no delegation, the user ecall lands in M
    writeCsr(3'b001, privPkg::csrMedeleg, 32'h0);
    drive(mretInstr, 32'h0000_0100, 1'b0, 1'b0, 32'h0);
    checkEq("privNextPcM", privNextPcM, 32'h0000_2004);
    endCycle();
    checkMode(privPkg::modeU);
    drive(ecallInstr, 32'h0000_2004, 1'b0, 1'b0, 32'h0);
    checkBit("trapM", trapM, 1'b1);
    checkEq("privNextPcM", privNextPcM, 32'h0000_0100);
    endCycle();
    checkMode(privPkg::modeM);
    expectCsr("mcause", privPkg::csrMcause, 32'd8);

    // page fault from fetch walks three stages
    faultF.instrPageFault = 1'b1;
    drive(nopInstr, 32'h0000_4000, 1'b0, 1'b0, 32'h0);
    waitForTrap(edges);
    checkEq("fault edges", edges, 32'd3);
    checkEq("privNextPcM", privNextPcM, 32'h0000_0100);
    endCycle();
    expectCsr("mcause", privPkg::csrMcause, 32'd12);
    expectCsr("mtval", privPkg::csrMtval, 32'h0000_4000);

    // flush of D squashes the fault
    faultF.instrPageFault = 1'b1;
    flushD = 1'b1;
    drive(nopInstr, 32'h0000_4100, 1'b0, 1'b0, 32'h0);
    @(posedge clk);
    @(negedge clk);
    faultF = '0;
    flushD = 1'b0;
    #settleTime;
    observeNoTrap(6);
    endCycle();

    // machine timer interrupt with mstatus.mie set
    writeCsr(3'b001, privPkg::csrMie, 32'h0000_0080);
    writeCsr(3'b010, privPkg::csrMstatus, 32'h0000_0008);
    intM.timerInt = 1'b1;
    drive(nopInstr, 32'h0000_5000, 1'b0, 1'b0, 32'h0);
    waitForTrap(edges);
    endCycle();
    expectCsr("mcause", privPkg::csrMcause, 32'h8000_0007);
    expectCsr("mepc", privPkg::csrMepc, 32'h0000_5000);

    // the trap cleared mstatus.mie, so M ignores the request
    intM.timerInt = 1'b1;
    drive(nopInstr, 32'h0000_5004, 1'b0, 1'b0, 32'h0);
    observeNoTrap(4);
    endCycle();

    // clear mpp and mpie, so mret leaves mstatus.mie clear in U
    writeCsr(3'b011, privPkg::csrMstatus, 32'h0000_1880);
    expectCsr("mstatus", privPkg::csrMstatus, 32'h0);
    writeCsr(3'b001, privPkg::csrMepc, 32'h0000_6000);
    drive(mretInstr, 32'h0000_5008, 1'b0, 1'b0, 32'h0);
    endCycle();
    checkMode(privPkg::modeU);
    // in U the request is taken even with mstatus.mie clear
    intM.timerInt = 1'b1;
    drive(nopInstr, 32'h0000_6000, 1'b0, 1'b0, 32'h0);
    waitForTrap(edges);
    checkEq("privNextPcM", privNextPcM, 32'h0000_0100);
    endCycle();
    checkMode(privPkg::modeM);
    expectCsr("mcause", privPkg::csrMcause, 32'h8000_0007);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: source/privileged.sv
// privileged unit top with fault pipeline, privilege mode and trap wiring
`timescale 1ns/1ps

module privileged (
  input  logic                clk,
  input  logic                rstN,
  input  logic                stallD,
  input  logic                stallE,
  input  logic                stallM,
  input  logic                stallW,
  input  logic                flushD,
  input  logic                flushE,
  input  logic                flushM,
  input  privPkg::instrFaultT faultF,
  input  logic                illegalInstrD,
  input  logic                instrValidM,
  input  privPkg::xlenT       instrM,
  input  privPkg::xlenT       pcM,
  input  logic                csrReadM,
  input  logic                csrWriteM,
  input  privPkg::xlenT       srcAM,
  input  logic                loadAccessFaultM,
  input  logic                storeAccessFaultM,
  input  privPkg::xlenT       memAdrM,
  input  privPkg::intLinesT   intM,
  output privPkg::xlenT       csrReadValW,
  output privPkg::xlenT       privNextPcM,
  output logic                trapM,
  output logic                retM,
  output logic                tlbFlushM,
  output privPkg::privModeT   privilegeModeW,
  output logic                statusSum,
  output logic                statusMxr,
  output logic                statusMprv,
  output logic [1:0]          statusMpp
);

  privPkg::instrFaultT faultDIn;
  privPkg::instrFaultT faultEIn;
  privPkg::instrFaultT faultD;
  privPkg::instrFaultT faultE;
  privPkg::instrFaultT faultM;
  privPkg::privOpT     privOp;
  privPkg::statusT     status;
  privPkg::trapInfoT   trapInfo;
  privPkg::privModeT   nextModeM;
  privPkg::xlenT       mtvec;
  privPkg::xlenT       stvec;
  privPkg::xlenT       mepc;
  privPkg::xlenT       sepc;
  privPkg::xlenT       medeleg;
  privPkg::xlenT       mideleg;
  privPkg::xlenT       mie;
  logic                illegalCsrM;

  ////////////////////
  // fault pipeline
  ////////////////////
  // fetch has no illegal bit, decode adds its own on the way to E
  always_comb begin
    faultDIn = faultF;
    faultDIn.illegalInstr = 1'b0;
    faultEIn = faultD;
    faultEIn.illegalInstr = illegalInstrD;
  end

  // flush wins over stall
  always_ff @(posedge clk) begin
    if (!rstN) begin
      faultD <= '0;
      faultE <= '0;
      faultM <= '0;
    end else begin
      if (flushD) faultD <= '0;
      else if (!stallD) faultD <= faultDIn;
      if (flushE) faultE <= '0;
      else if (!stallE) faultE <= faultEIn;
      if (flushM) faultM <= '0;
      else if (!stallM) faultM <= faultE;
    end
  end

  // privilege mode, M out of reset
  always_ff @(posedge clk) begin
    if (!rstN) privilegeModeW <= privPkg::modeM;
    else if (!stallW) privilegeModeW <= nextModeM;
  end

  privDecoder privDecoderInst (
    .instrM        (instrM),
    .instrValidM   (instrValidM),
    .privilegeMode (privilegeModeW),
    .status        (status),
    .privOp        (privOp)
  );

  csrFile csrFileInst (
    .clk, .rstN, .stallW, .csrReadM, .csrWriteM, .instrM, .srcAM,
    .privilegeMode (privilegeModeW),
    .privOp, .trapInfo, .pcM, .intM, .status,
    .mtvec, .stvec, .mepc, .sepc, .medeleg, .mideleg, .mie,
    .illegalCsrM, .csrReadValW
  );

  trapUnit trapUnitInst (
    .privilegeMode (privilegeModeW),
    .instrValidM, .faultM, .privOp, .illegalCsrM,
    .loadAccessFaultM, .storeAccessFaultM,
    .pcM, .instrM, .memAdrM, .intM, .status,
    .mie, .medeleg, .mideleg, .mtvec, .stvec, .mepc, .sepc,
    .trapInfo, .trapM, .retM, .tlbFlushM, .nextModeM, .privNextPcM
  );

  // status bits the MMU side needs
  assign statusSum  = status.sum;
  assign statusMxr  = status.mxr;
  assign statusMprv = status.mprv;
  assign statusMpp  = status.mpp;

endmodule

// File: source/trapUnit.sv
// trap selection with delegation, cause, trap value, target mode and redirect PC
`timescale 1ns/1ps

module trapUnit (
  input  privPkg::privModeT  privilegeMode,
  input  logic               instrValidM,
  input  privPkg::instrFaultT faultM,
  input  privPkg::privOpT    privOp,
  input  logic               illegalCsrM,
  input  logic               loadAccessFaultM,
  input  logic               storeAccessFaultM,
  input  privPkg::xlenT      pcM,
  input  privPkg::xlenT      instrM,
  input  privPkg::xlenT      memAdrM,
  input  privPkg::intLinesT  intM,
  input  privPkg::statusT    status,
  input  privPkg::xlenT      mie,
  input  privPkg::xlenT      medeleg,
  input  privPkg::xlenT      mideleg,
  input  privPkg::xlenT      mtvec,
  input  privPkg::xlenT      stvec,
  input  privPkg::xlenT      mepc,
  input  privPkg::xlenT      sepc,
  output privPkg::trapInfoT  trapInfo,
  output logic               trapM,
  output logic               retM,
  output logic               tlbFlushM,
  output privPkg::privModeT  nextModeM,
  output privPkg::xlenT      privNextPcM
);

  privPkg::xlenT  pendingInt;
  privPkg::xlenT  enabledInt;
  privPkg::causeT cause;
  privPkg::causeT ecallCause;
  privPkg::xlenT  tval;
  logic           mLevelOn;
  logic           sLevelOn;
  logic           illegalAny;
  logic           excValid;
  logic           delegated;
  logic           toSuperM;
  logic           mretM;
  logic           sretM;

  ////////////////////
  // interrupt enables
  ////////////////////
  // machine interrupts need a lower mode or mstatus.mie
  assign mLevelOn = (privilegeMode != privPkg::modeM) || status.mie;
  // delegated ones are never taken in M, and in S only with sie
  assign sLevelOn = (privilegeMode == privPkg::modeU) ||
                    ((privilegeMode == privPkg::modeS) && status.sie);

  always_comb begin
    pendingInt = '0;
    pendingInt[privPkg::intSoftM]  = intM.swInt;
    pendingInt[privPkg::intTimerM] = intM.timerInt;
    pendingInt[privPkg::intExtM]   = intM.extInt;
    pendingInt = pendingInt & mie;
    for (int i = 0; i < privPkg::xlen; i++) begin
      enabledInt[i] = pendingInt[i] && (mideleg[i] ? sLevelOn : mLevelOn);
    end
  end

  assign illegalAny = faultM.illegalInstr || privOp.illegalPriv || illegalCsrM;

  // ecall cause follows the mode it came from
  always_comb begin
    case (privilegeMode)
      privPkg::modeM: ecallCause = privPkg::causeEcallM;
      privPkg::modeS: ecallCause = privPkg::causeEcallS;
      default:        ecallCause = privPkg::causeEcallU;
    endcase
  end

  ////////////////////
  // priority select
  ////////////////////
  always_comb begin
    excValid = 1'b1;
    cause    = '0;
    tval     = '0;
    // highest numbered interrupt first
    if (enabledInt[privPkg::intExtM]) cause = privPkg::intBit | privPkg::intExtM;
    else if (enabledInt[privPkg::intTimerM]) cause = privPkg::intBit | privPkg::intTimerM;
    else if (enabledInt[privPkg::intSoftM]) cause = privPkg::intBit | privPkg::intSoftM;
    else if (faultM.instrPageFault) begin
      cause = privPkg::causeInstrPage;
      tval  = pcM;
    end else if (faultM.instrAccessFault) begin
      cause = privPkg::causeInstrAccess;
      tval  = pcM;
    end else if (illegalAny) begin
      cause = privPkg::causeIllegal;
      tval  = instrM;
    end else if (privOp.ebreak) cause = privPkg::causeBreakpoint;
    else if (privOp.ecall) cause = ecallCause;
    else if (loadAccessFaultM) begin
      cause = privPkg::causeLoadAccess;
      tval  = memAdrM;
    end else if (storeAccessFaultM) begin
      cause = privPkg::causeStoreAccess;
      tval  = memAdrM;
    end else excValid = 1'b0;
  end

  assign trapM = instrValidM && excValid;

  // the low cause bits index the delegation register
  assign delegated = cause[privPkg::xlen-1] ? mideleg[cause[4:0]] : medeleg[cause[4:0]];
  assign toSuperM  = trapM && (privilegeMode != privPkg::modeM) && delegated;

  assign trapInfo = '{trap: trapM, toSuper: toSuperM, cause: cause, tval: tval};

  // a trap cancels returns and TLB flushes of the same instruction
  assign mretM     = privOp.mret && !trapM;
  assign sretM     = privOp.sret && !trapM;
  assign retM      = mretM || sretM;
  assign tlbFlushM = privOp.sfenceVma && !trapM;

  always_comb begin
    if (trapM) nextModeM = toSuperM ? privPkg::modeS : privPkg::modeM;
    else if (mretM) nextModeM = status.mpp;
    else if (sretM) nextModeM = status.spp ? privPkg::modeS : privPkg::modeU;
    else nextModeM = privilegeMode;
  end

  // direct mode only, so the vector is the base itself
  always_comb begin
    if (mretM) privNextPcM = mepc;
    else if (sretM) privNextPcM = sepc;
    else if (toSuperM) privNextPcM = stvec;
    else privNextPcM = mtvec;
  end

endmodule

// File: source/csrFile.sv
// reduced machine and supervisor CSR file with trap and return side effects
`timescale 1ns/1ps

module csrFile (
  input  logic              clk,
  input  logic              rstN,
  input  logic              stallW,
  input  logic              csrReadM,
  input  logic              csrWriteM,
  input  privPkg::xlenT     instrM,
  input  privPkg::xlenT     srcAM,
  input  privPkg::privModeT privilegeMode,
  input  privPkg::privOpT   privOp,
  input  privPkg::trapInfoT trapInfo,
  input  privPkg::xlenT     pcM,
  input  privPkg::intLinesT intM,
  output privPkg::statusT   status,
  output privPkg::xlenT     mtvec,
  output privPkg::xlenT     stvec,
  output privPkg::xlenT     mepc,
  output privPkg::xlenT     sepc,
  output privPkg::xlenT     medeleg,
  output privPkg::xlenT     mideleg,
  output privPkg::xlenT     mie,
  output logic              illegalCsrM,
  output privPkg::xlenT     csrReadValW
);

  privPkg::csrAddrT csrAddr;
  privPkg::causeT   mcause;
  privPkg::causeT   scause;
  privPkg::xlenT    mtval;
  privPkg::xlenT    stval;
  privPkg::xlenT    mstatusVal;
  privPkg::xlenT    mipVal;
  privPkg::xlenT    readVal;
  privPkg::xlenT    writeVal;
  logic             knownAddr;
  logic             csrWe;
  logic             mretDone;
  logic             sretDone;

  assign csrAddr = instrM[31:20];

  ////////////////////
  // read side
  ////////////////////
  // mstatus image at spec bit positions
  always_comb begin
    mstatusVal = '0;
    mstatusVal[1]     = status.sie;
    mstatusVal[3]     = status.mie;
    mstatusVal[5]     = status.spie;
    mstatusVal[7]     = status.mpie;
    mstatusVal[8]     = status.spp;
    mstatusVal[12:11] = status.mpp;
    mstatusVal[17]    = status.mprv;
    mstatusVal[18]    = status.sum;
    mstatusVal[19]    = status.mxr;
    mstatusVal[22]    = status.tsr;
  end

  // mip has no storage, it mirrors the request lines
  always_comb begin
    mipVal = '0;
    mipVal[privPkg::intSoftM]  = intM.swInt;
    mipVal[privPkg::intTimerM] = intM.timerInt;
    mipVal[privPkg::intExtM]   = intM.extInt;
  end

  always_comb begin
    readVal   = '0;
    knownAddr = 1'b1;
    case (csrAddr)
      privPkg::csrMstatus: readVal = mstatusVal;
      privPkg::csrSstatus: readVal = mstatusVal & privPkg::sstatusMask;
      privPkg::csrMedeleg: readVal = medeleg;
      privPkg::csrMideleg: readVal = mideleg;
      privPkg::csrMie:     readVal = mie;
      privPkg::csrMip:     readVal = mipVal;
      privPkg::csrMtvec:   readVal = mtvec;
      privPkg::csrMepc:    readVal = mepc;
      privPkg::csrMcause:  readVal = mcause;
      privPkg::csrMtval:   readVal = mtval;
      privPkg::csrStvec:   readVal = stvec;
      privPkg::csrSepc:    readVal = sepc;
      privPkg::csrScause:  readVal = scause;
      privPkg::csrStval:   readVal = stval;
      default:             knownAddr = 1'b0;
    endcase
  end

  // funct3 low bits pick csrrw, csrrs or csrrc
  always_comb begin
    case (instrM[13:12])
      2'b10:   writeVal = readVal | srcAM;
      2'b11:   writeVal = readVal & ~srcAM;
      default: writeVal = srcAM;
    endcase
  end

  // bits 9:8 give the lowest mode allowed, 11:10 all ones is read-only
  assign illegalCsrM = (csrReadM || csrWriteM) &&
                       (!knownAddr || (csrAddr[9:8] > privilegeMode) ||
                        (csrWriteM && (csrAddr[11:10] == 2'b11)));

  // a trapping instruction never writes
  assign csrWe    = csrWriteM && !illegalCsrM && !trapInfo.trap;
  assign mretDone = privOp.mret && !trapInfo.trap;
  assign sretDone = privOp.sret && !trapInfo.trap;

  ////////////////////
  // state update
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      status  <= '0;
      mtvec   <= '0;
      stvec   <= '0;
      mepc    <= '0;
      sepc    <= '0;
      mcause  <= '0;
      scause  <= '0;
      mtval   <= '0;
      stval   <= '0;
      medeleg <= '0;
      mideleg <= '0;
      mie     <= '0;
    end else if (!stallW) begin
      if (trapInfo.trap) begin
        if (trapInfo.toSuper) begin
          sepc        <= pcM & privPkg::epcMask;
          scause      <= trapInfo.cause;
          stval       <= trapInfo.tval;
          status.spie <= status.sie;
          status.sie  <= 1'b0;
          // spp only tells S from U
          status.spp  <= (privilegeMode == privPkg::modeS);
        end else begin
          mepc        <= pcM & privPkg::epcMask;
          mcause      <= trapInfo.cause;
          mtval       <= trapInfo.tval;
          status.mpie <= status.mie;
          status.mie  <= 1'b0;
          status.mpp  <= privilegeMode;
        end
      end else if (mretDone) begin
        status.mie  <= status.mpie;
        status.mpie <= 1'b1;
        status.mpp  <= privPkg::modeU;
      end else if (sretDone) begin
        status.sie <= status.spie;
        status.spp <= 1'b0;
      end else if (csrWe) begin
        case (csrAddr)
          privPkg::csrMstatus: begin
            status.sie  <= writeVal[1];
            status.mie  <= writeVal[3];
            status.spie <= writeVal[5];
            status.mpie <= writeVal[7];
            status.spp  <= writeVal[8];
            status.mprv <= writeVal[17];
            status.sum  <= writeVal[18];
            status.mxr  <= writeVal[19];
            status.tsr  <= writeVal[22];
            // reserved mode 2 keeps the old mpp
            if (writeVal[12:11] != 2'b10)
              status.mpp <= privPkg::privModeT'(writeVal[12:11]);
          end
          privPkg::csrSstatus: begin
            status.sie  <= writeVal[1];
            status.spie <= writeVal[5];
            status.spp  <= writeVal[8];
            status.sum  <= writeVal[18];
            status.mxr  <= writeVal[19];
          end
          privPkg::csrMedeleg: medeleg <= writeVal & privPkg::medelegMask;
          privPkg::csrMideleg: mideleg <= writeVal & privPkg::intMask;
          privPkg::csrMie:     mie     <= writeVal & privPkg::intMask;
          privPkg::csrMtvec:   mtvec   <= writeVal & privPkg::tvecMask;
          privPkg::csrMepc:    mepc    <= writeVal & privPkg::epcMask;
          privPkg::csrMcause:  mcause  <= writeVal;
          privPkg::csrMtval:   mtval   <= writeVal;
          privPkg::csrStvec:   stvec   <= writeVal & privPkg::tvecMask;
          privPkg::csrSepc:    sepc    <= writeVal & privPkg::epcMask;
          privPkg::csrScause:  scause  <= writeVal;
          privPkg::csrStval:   stval   <= writeVal;
          default: ;
        endcase
      end
    end
  end

  // read data lands in W one cycle later
  always_ff @(posedge clk) begin
    if (!rstN) csrReadValW <= '0;
    else if (!stallW) csrReadValW <= readVal;
  end

endmodule

// File: source/privDecoder.sv
// memory-stage decoder for mret, sret, ecall, ebreak, wfi and sfence.vma
`timescale 1ns/1ps

module privDecoder (
  input  privPkg::xlenT     instrM,
  input  logic              instrValidM,
  input  privPkg::privModeT privilegeMode,
  input  privPkg::statusT   status,
  output privPkg::privOpT   privOp
);

  logic isSystem;
  logic noRegs;
  logic mretRaw;
  logic sretRaw;
  logic sretTrapped;

  // SYSTEM opcode, funct3 zero
  assign isSystem = (instrM[6:0] == 7'b1110011) && (instrM[14:12] == 3'b000);
  // rs1 and rd both x0
  assign noRegs = (instrM[19:15] == 5'd0) && (instrM[11:7] == 5'd0);

  // returns are told apart by the immediate field
  assign mretRaw = isSystem && noRegs && (instrM[31:20] == 12'h302);
  assign sretRaw = isSystem && noRegs && (instrM[31:20] == 12'h102);

  // sret is off limits in U, and in S while tsr is set
  assign sretTrapped = (privilegeMode == privPkg::modeU) ||
                       ((privilegeMode == privPkg::modeS) && status.tsr);

  always_comb begin
    privOp = '0;
    if (instrValidM) begin
      privOp.mret   = mretRaw;
      privOp.sret   = sretRaw;
      privOp.ecall  = isSystem && noRegs && (instrM[31:20] == 12'h000);
      privOp.ebreak = isSystem && noRegs && (instrM[31:20] == 12'h001);
      privOp.wfi    = isSystem && noRegs && (instrM[31:20] == 12'h105);
      // sfence.vma takes rs1 and rs2, only rd must be x0
      privOp.sfenceVma = isSystem && (instrM[31:25] == 7'b0001001) &&
                         (instrM[11:7] == 5'd0);
      // mret needs M mode
      privOp.illegalPriv = (mretRaw && (privilegeMode != privPkg::modeM)) ||
                           (sretRaw && sretTrapped);
    end
  end

endmodule

// File: source/privPkg.sv
// privileged unit package with widths, modes, CSR map, cause codes and shared structs
package privPkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] xlenT;
  typedef logic [11:0]     csrAddrT;
  typedef logic [xlen-1:0] causeT;

  // spec encoding, 2'b10 stays reserved
  typedef enum logic [1:0] {
    modeU = 2'b00,
    modeS = 2'b01,
    modeM = 2'b11
  } privModeT;

  ////////////////////
  // csr addresses
  ////////////////////
  localparam csrAddrT csrSstatus = 12'h100;
  localparam csrAddrT csrStvec   = 12'h105;
  localparam csrAddrT csrSepc    = 12'h141;
  localparam csrAddrT csrScause  = 12'h142;
  localparam csrAddrT csrStval   = 12'h143;
  localparam csrAddrT csrMstatus = 12'h300;
  localparam csrAddrT csrMedeleg = 12'h302;
  localparam csrAddrT csrMideleg = 12'h303;
  localparam csrAddrT csrMie     = 12'h304;
  localparam csrAddrT csrMtvec   = 12'h305;
  localparam csrAddrT csrMepc    = 12'h341;
  localparam csrAddrT csrMcause  = 12'h342;
  localparam csrAddrT csrMtval   = 12'h343;
  localparam csrAddrT csrMip     = 12'h344;

  ////////////////////
  // cause codes
  ////////////////////
  localparam causeT causeInstrAccess = 32'd1;
  localparam causeT causeIllegal     = 32'd2;
  localparam causeT causeBreakpoint  = 32'd3;
  localparam causeT causeLoadAccess  = 32'd5;
  localparam causeT causeStoreAccess = 32'd7;
  localparam causeT causeEcallU      = 32'd8;
  localparam causeT causeEcallS      = 32'd9;
  localparam causeT causeEcallM      = 32'd11;
  localparam causeT causeInstrPage   = 32'd12;
  // interrupt numbers, the top bit is added on the way out
  localparam causeT intSoftM  = 32'd3;
  localparam causeT intTimerM = 32'd7;
  localparam causeT intExtM   = 32'd11;
  localparam causeT intBit    = 32'h8000_0000;

  // legal bits of the WARL registers
  localparam xlenT tvecMask    = 32'hffff_fffc;
  localparam xlenT epcMask     = 32'hffff_fffc;
  localparam xlenT medelegMask = 32'h0000_ffff;
  localparam xlenT intMask     = 32'h0000_0888;
  // sie, spie, spp, sum, mxr as seen through sstatus
  localparam xlenT sstatusMask = 32'h000c_0122;

  ////////////////////
  // shared structs
  ////////////////////
  // faults that ride the pipeline from fetch and decode
  typedef struct packed {
    logic instrPageFault;
    logic instrAccessFault;
    logic illegalInstr;
  } instrFaultT;

  typedef struct packed {
    logic mret;
    logic sret;
    logic ecall;
    logic ebreak;
    logic wfi;
    logic sfenceVma;
    logic illegalPriv;
  } privOpT;

  // live mstatus fields
  typedef struct packed {
    logic     mie;
    logic     sie;
    logic     mpie;
    logic     spie;
    privModeT mpp;
    logic     spp;
    logic     tsr;
    logic     sum;
    logic     mxr;
    logic     mprv;
  } statusT;

  typedef struct packed {
    logic  trap;
    logic  toSuper;
    causeT cause;
    xlenT  tval;
  } trapInfoT;

  typedef struct packed {
    logic swInt;
    logic timerInt;
    logic extInt;
  } intLinesT;

endpackage
